// ==== compile.f ====
+incdir+include
verilog/cache_pkg.sv
verilog/line_fill_if.sv
verilog/cache_ram.sv
verilog/cache_line_fill.sv
verilog/cache_lookup_ctrl.sv
verilog/cache_top.sv
sim/cache_props.sv
sim/cache_tb.sv

// ==== include/cache_consts.svh ====
`ifndef CACHE_CONSTS_SVH
`define CACHE_CONSTS_SVH

// address split: tag | index | word select | byte offset
`define CACHE_ADDR_W      16
`define CACHE_WORD_W      32
`define CACHE_BYTE_OFF_W  2
`define CACHE_LINE_OFF_W  2   // 4 words per line
`define CACHE_INDEX_W     4   // 16 lines
`define CACHE_TAG_W       (`CACHE_ADDR_W - `CACHE_INDEX_W - `CACHE_LINE_OFF_W - `CACHE_BYTE_OFF_W)

// AXI4 read channel constants
`define CACHE_AXI_ID          0
`define CACHE_AXI_ID_W        1
`define CACHE_AXI_BURST_INCR  2'b01
`define CACHE_AXI_RESP_OKAY   2'b00
`define CACHE_AXI_LOCK        1'b0
`define CACHE_AXI_CACHE       4'b0011  // normal, non-cacheable, bufferable
`define CACHE_AXI_PROT        3'b000
`define CACHE_AXI_QOS         4'b0000

`endif

// ==== sim/cache_props.sv ====
`timescale 1ns/1ns
`include "cache_consts.svh"

// AXI read channel and front port rules, bound into cache_top
module cache_props (
   input logic                     clk,
   input logic                     reset,
   input logic                     arvalid,
   input logic [`CACHE_ADDR_W-1:0] araddr,
   input logic                     arready,
   input logic [7:0]               arlen,
   input logic                     rready,
   input logic                     rsp_valid,
   input logic                     replace
);

   int assert_failures = 0;  // summed into the testbench error count

   // an offered address waits for arready unchanged
   property ar_held;
      @(posedge clk) disable iff (reset)
         arvalid && !arready |=> arvalid && $stable(araddr);
   endproperty

   property ar_r_exclusive;
      @(posedge clk) disable iff (reset) !(rready && arvalid);
   endproperty

   property no_rsp_during_refill;
      @(posedge clk) disable iff (reset) !(rsp_valid && replace);
   endproperty

   property burst_len_fixed;
      @(posedge clk) disable iff (reset) arlen == 8'd3;  // four beats per line
   endproperty

   ar_held_a: assert property (ar_held)
      else begin
         $error("arvalid dropped or araddr changed before arready");
         assert_failures++;
      end

   ar_r_exclusive_a: assert property (ar_r_exclusive)
      else begin
         $error("rready high together with arvalid");
         assert_failures++;
      end

   no_rsp_during_refill_a: assert property (no_rsp_during_refill)
      else begin
         $error("rsp_valid while the refill engine is busy");
         assert_failures++;
      end

   burst_len_fixed_a: assert property (burst_len_fixed)
      else begin
         $error("arlen is not 3");
         assert_failures++;
      end

endmodule

// ==== sim/cache_tb.sv ====
`timescale 1ns/1ns
`include "cache_consts.svh"

module cache_tb;
   import cache_pkg::*;

   localparam int TIMEOUT = 200;  // cycles allowed for each wait

   logic                       clk;
   logic                       reset;
   logic                       req_valid;
   cache_addr_t                req_addr;
   logic                       req_ready;
   logic                       rsp_valid;
   word_t                      rsp_rdata;
   logic                       arvalid;
   logic [`CACHE_ADDR_W-1:0]   araddr;
   logic [7:0]                 arlen;
   logic [2:0]                 arsize;
   logic [1:0]                 arburst;
   logic                       arlock;
   logic [3:0]                 arcache;
   logic [2:0]                 arprot;
   logic [3:0]                 arqos;
   logic [`CACHE_AXI_ID_W-1:0] arid;
   logic                       arready;
   logic                       rvalid;
   word_t                      rdata;
   logic [1:0]                 rresp;
   logic                       rlast;
   logic                       rready;

   integer seed = 32'h95dd_3374;
   string  test_name;
   int     errors;
   int     checks;
   int     tests_run;
   int     errors_at_start;
   logic   timed_out;

   // memory model state
   logic                     stall_en;
   logic                     err_pending;  // corrupt one beat of the next burst
   int                       err_beat;
   int                       ar_count;
   logic                     in_burst;
   int                       beat;
   logic [`CACHE_ADDR_W-1:0] burst_addr;
   logic [`CACHE_ADDR_W-1:0] last_araddr;
   int                       last_arlen;
   int                       last_arsize;
   int                       last_arburst;
   int                       last_arid;
   logic                     last_arlock;
   int                       last_arcache;
   int                       last_arprot;
   int                       last_arqos;

   // reference tag store
   tag_t model_tag [16];
   logic model_valid [16];

   cache_top i_dut (.*);

   bind cache_top cache_props i_props (
      .clk       (clk),
      .reset     (reset),
      .arvalid   (arvalid),
      .araddr    (araddr),
      .arready   (arready),
      .arlen     (arlen),
      .rready    (rready),
      .rsp_valid (rsp_valid),
      .replace   (fill_bus.replace)
   );

   initial clk = 1'b0;
   always #5 clk = ~clk;

   function automatic word_t mem_word(input logic [`CACHE_ADDR_W-1:0] byte_addr);
      return {byte_addr, ~byte_addr};
   endfunction

   // AXI slave, decides each handshake for the coming rising edge
   always @(negedge clk) begin : axi_memory
      logic stall;
      stall   = 1'b0;
      arready = 1'b0;
      rvalid  = 1'b0;
      rlast   = 1'b0;
      rresp   = `CACHE_AXI_RESP_OKAY;
      if (stall_en && (arvalid || rready)) begin
         stall = (($random(seed) & 3) == 0);  // about one cycle in four
      end
      if (!reset && !stall) begin
         if (!in_burst && arvalid) begin
            arready      = 1'b1;
            ar_count++;
            last_araddr  = araddr;
            last_arlen   = arlen;
            last_arsize  = arsize;
            last_arburst = arburst;
            last_arid    = arid;
            last_arlock  = arlock;
            last_arcache = arcache;
            last_arprot  = arprot;
            last_arqos   = arqos;
            burst_addr   = araddr;
            beat         = 0;
            in_burst     = 1'b1;
         end else if (in_burst && rready) begin
            rvalid = 1'b1;
            rlast  = (beat == 3);
            rdata  = mem_word(burst_addr + 16'(4 * beat));
            if (err_pending && beat == err_beat) begin
               rresp       = 2'b10;  // SLVERR
               rdata       = 32'hdead_beef;
               err_pending = 1'b0;
            end
            if (beat == 3) begin
               in_burst = 1'b0;
            end else begin
               beat++;
            end
         end
      end
   end

   task automatic check_word(input string what, input word_t expected, input word_t actual);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("[FAIL] %s: %s expected %h actual %h", test_name, what, expected, actual);
      end
   endtask

   task automatic check_count(input string what, input int expected, input int actual);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("[FAIL] %s: %s expected %0d actual %0d", test_name, what, expected, actual);
      end
   endtask

   task automatic check_bit(input string what, input logic expected, input logic actual);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("[FAIL] %s: %s expected %b actual %b", test_name, what, expected, actual);
      end
   endtask

   task automatic report_timeout(input string what);
      $display("%s: timed out waiting for %s after %0d cycles", test_name, what, TIMEOUT);
      timed_out = 1'b1;
      forever @(negedge clk);  // the run ends in watch_timeout
   endtask

   initial begin : watch_timeout
      wait (timed_out === 1'b1);
      $display("Simulation failed");
      $finish;
   end

   task automatic begin_test(input string name);
      test_name       = name;
      errors_at_start = errors;
      tests_run++;
   endtask

   task automatic end_test();
      if (errors == errors_at_start) begin
         $display("test %s: ok", test_name);
      end else begin
         $display("test %s: %0d errors", test_name, errors - errors_at_start);
      end
   endtask

   // one request on the front port, latency counts cycles from acceptance
   task automatic read_word(input logic [15:0] addr, output word_t data, output int latency,
                            output logic ready_after);
      int wait_cnt;
      @(negedge clk);
      req_valid = 1'b1;
      req_addr  = addr;
      wait_cnt  = 0;
      while (!req_ready) begin
         @(negedge clk);
         wait_cnt++;
         if (wait_cnt > TIMEOUT) report_timeout("req_ready");
      end
      @(negedge clk);  // accepted on the rising edge before
      req_valid   = 1'b0;
      latency     = 1;
      ready_after = req_ready;
      while (!rsp_valid) begin
         @(negedge clk);
         latency++;
         if (latency > TIMEOUT) report_timeout("rsp_valid");
      end
      data = rsp_rdata;
      @(negedge clk);
      check_bit("single rsp_valid pulse", 1'b0, rsp_valid);
   endtask

   // predicts hit or miss from the tag model, then checks data and hit timing
   task automatic checked_read(input logic [15:0] addr, output logic predicted,
                               output logic miss);
      cache_addr_t a;
      word_t       data;
      int          latency;
      logic        ready_after;
      a         = addr;
      predicted = !(model_valid[a.index] && model_tag[a.index] == a.tag);
      model_valid[a.index] = 1'b1;
      model_tag[a.index]   = a.tag;
      read_word(addr, data, latency, ready_after);
      miss = !ready_after;  // a miss drops req_ready the cycle after acceptance
      check_word($sformatf("data at %h", addr), mem_word({addr[15:2], 2'b00}), data);
      check_bit($sformatf("miss at %h against tag model", addr), predicted, miss);
      if (!predicted) begin
         check_count($sformatf("hit latency at %h", addr), 1, latency);
      end
   endtask

   task automatic test_after_reset();
      begin_test("after_reset");
      check_bit("req_ready", 1'b1, req_ready);
      check_bit("rsp_valid", 1'b0, rsp_valid);
      check_bit("arvalid", 1'b0, arvalid);
      check_bit("rready", 1'b0, rready);
      end_test();
   endtask

   task automatic test_cold_miss();
      logic predicted;
      logic miss;
      int   ar_start;
      begin_test("cold_miss");
      ar_start = ar_count;
      checked_read(16'h3a54, predicted, miss);
      check_bit("miss", 1'b1, miss);
      check_count("AR handshakes", 1, ar_count - ar_start);
      check_word("araddr", 32'h0000_3a50, word_t'(last_araddr));
      check_count("arlen", 3, last_arlen);
      check_count("arsize", 2, last_arsize);
      check_count("arburst", 1, last_arburst);
      check_count("arid", `CACHE_AXI_ID, last_arid);
      check_bit("arlock", `CACHE_AXI_LOCK, last_arlock);
      check_count("arcache", `CACHE_AXI_CACHE, last_arcache);
      check_count("arprot", `CACHE_AXI_PROT, last_arprot);
      check_count("arqos", `CACHE_AXI_QOS, last_arqos);
      end_test();
   endtask

   task automatic test_hits();
      logic predicted;
      logic miss;
      int   ar_start;
      begin_test("hits");
      ar_start = ar_count;
      for (int w = 0; w < 4; w++) begin
         checked_read(16'h3a50 + 16'(4 * w), predicted, miss);
         check_bit("hit", 1'b0, miss);
      end
      check_count("AR handshakes", 0, ar_count - ar_start);
      end_test();
   endtask

   task automatic test_conflict();
      logic predicted;
      logic miss;
      int   ar_start;
      begin_test("conflict");
      ar_start = ar_count;
      checked_read(16'h7b58, predicted, miss);  // same index, other tag
      check_bit("miss", 1'b1, miss);
      checked_read(16'h3a50, predicted, miss);
      check_bit("evicted line misses", 1'b1, miss);
      check_count("AR handshakes", 2, ar_count - ar_start);
      end_test();
   endtask

   task automatic test_slave_error();
      logic predicted;
      logic miss;
      int   ar_start;
      begin_test("slave_error");
      err_pending = 1'b1;
      err_beat    = 1;
      ar_start    = ar_count;
      checked_read(16'hc4e4, predicted, miss);  // word 1, the corrupted beat
      check_bit("error beat sent", 1'b0, err_pending);
      check_count("AR handshakes", 2, ar_count - ar_start);
      for (int w = 0; w < 4; w++) begin
         checked_read(16'hc4e0 + 16'(4 * w), predicted, miss);
      end
      check_count("AR handshakes after rereads", 2, ar_count - ar_start);
      end_test();
   endtask

   task automatic test_random_sweep();
      logic [15:0] addrs [$];
      logic        predicted;
      logic        miss;
      int          misses;
      int          ar_start;
      begin_test("random_sweep");
      // four tags only, so lines get reused
      for (int i = 0; i < 200; i++) begin
         addrs.push_back(16'($random(seed)) & 16'h03ff);
      end
      misses   = 0;
      ar_start = ar_count;
      stall_en = 1'b1;
      foreach (addrs[i]) begin
         checked_read(addrs[i], predicted, miss);
         if (predicted) misses++;
      end
      stall_en = 1'b0;
      check_count("AR handshakes against predicted misses", misses, ar_count - ar_start);
      end_test();
   endtask

   initial begin
      reset       = 1'b1;
      req_valid   = 1'b0;
      req_addr    = '0;
      arready     = 1'b0;
      rvalid      = 1'b0;
      rdata       = '0;
      rresp       = `CACHE_AXI_RESP_OKAY;
      rlast       = 1'b0;
      stall_en    = 1'b0;
      err_pending = 1'b0;
      err_beat    = 0;
      ar_count    = 0;
      in_burst    = 1'b0;
      beat        = 0;
      burst_addr  = '0;
      errors      = 0;
      checks      = 0;
      tests_run   = 0;
      timed_out   = 1'b0;
      foreach (model_valid[i]) model_valid[i] = 1'b0;
      repeat (3) @(negedge clk);
      reset = 1'b0;
      @(negedge clk);
      test_after_reset();
      test_cold_miss();
      test_hits();
      test_conflict();
      test_slave_error();
      test_random_sweep();
      errors += i_dut.i_props.assert_failures;
      $display("tests %0d, checks %0d, assertion failures %0d, errors %0d",
               tests_run, checks, i_dut.i_props.assert_failures, errors);
      if (errors == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

// ==== verilog/cache_line_fill.sv ====
`timescale 1ns/1ns
`include "cache_consts.svh"

module cache_line_fill (
   input  logic                       clk,
   input  logic                       reset,
   line_fill_if.fill                  fill,

   // AXI4 read address channel
   output logic                       arvalid,
   output logic [`CACHE_ADDR_W-1:0]   araddr,
   output logic [7:0]                 arlen,
   output logic [2:0]                 arsize,
   output logic [1:0]                 arburst,
   output logic                       arlock,
   output logic [3:0]                 arcache,
   output logic [2:0]                 arprot,
   output logic [3:0]                 arqos,
   output logic [`CACHE_AXI_ID_W-1:0] arid,
   input  logic                       arready,

   // AXI4 read data channel
   input  logic                       rvalid,
   input  cache_pkg::word_t           rdata,
   input  logic [1:0]                 rresp,
   input  logic                       rlast,
   output logic                       rready
);
   import cache_pkg::*;

   localparam int BEATS = 1 << `CACHE_LINE_OFF_W;
   localparam int OFF_W = `CACHE_LINE_OFF_W + `CACHE_BYTE_OFF_W;
   localparam logic [`CACHE_AXI_ID_W-1:0] AXI_ID = `CACHE_AXI_ID;

   typedef enum logic [1:0] {
      st_idle,
      st_addr,
      st_load,
      st_end
   } state_t;

   state_t     state;
   line_addr_t line_q;     // line being refilled
   word_sel_t  word_cnt;   // beat index, holds on the last beat
   logic       slave_err;  // sticky, a burst cannot be cut short

   // fixed burst shape
   assign arid    = AXI_ID;
   assign arlock  = `CACHE_AXI_LOCK;
   assign arcache = `CACHE_AXI_CACHE;
   assign arprot  = `CACHE_AXI_PROT;
   assign arqos   = `CACHE_AXI_QOS;
   assign arlen   = 8'(BEATS - 1);
   assign arsize  = 3'(`CACHE_BYTE_OFF_W);  // full bus word per beat
   assign arburst = `CACHE_AXI_BURST_INCR;
   assign araddr  = {line_q, {OFF_W{1'b0}}};  // line aligned

   assign arvalid = (state == st_addr);
   assign rready  = (state == st_load);

   assign fill.replace    = (state != st_idle);
   assign fill.read_valid = rready && rvalid;
   assign fill.read_addr  = word_cnt;
   assign fill.read_rdata = rdata;

   always_ff @(posedge clk) begin
      if (state == st_idle && fill.replace_valid) begin
         line_q <= fill.replace_addr;
      end
   end

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         state     <= st_idle;
         word_cnt  <= '0;
         slave_err <= 1'b0;
      end else begin
         case (state)
            st_idle: begin
               if (fill.replace_valid) begin
                  state <= st_addr;
               end
            end
            st_addr: begin
               // a retry restarts from the first word
               word_cnt  <= '0;
               slave_err <= 1'b0;
               if (arready) begin
                  state <= st_load;
               end
            end
            st_load: begin
               if (rvalid) begin
                  if (rresp != `CACHE_AXI_RESP_OKAY) begin
                     slave_err <= 1'b1;
                  end
                  if (rlast) begin
                     state <= st_end;
                  end else begin
                     word_cnt <= word_cnt + 1'b1;
                  end
               end
            end
            default: begin
               // one cycle for the last data RAM write, then done or reissue
               state <= slave_err ? st_addr : st_idle;
            end
         endcase
      end
   end

endmodule

// ==== verilog/cache_lookup_ctrl.sv ====
`timescale 1ns/1ns
`include "cache_consts.svh"

module cache_lookup_ctrl (
   input  logic                                        clk,
   input  logic                                        reset,

   // front port
   input  logic                                        req_valid,
   input  cache_pkg::cache_addr_t                      req_addr,
   output logic                                        req_ready,
   output logic                                        rsp_valid,
   output cache_pkg::word_t                            rsp_rdata,

   // tag and data RAMs
   output logic [`CACHE_INDEX_W-1:0]                   tag_addr,
   output logic                                        tag_we,
   output cache_pkg::tag_t                             tag_wdata,
   input  cache_pkg::tag_t                             tag_rdata,
   output logic [`CACHE_INDEX_W+`CACHE_LINE_OFF_W-1:0] data_addr,
   input  cache_pkg::word_t                            data_rdata,

   line_fill_if.ctrl                                   ctl
);
   import cache_pkg::*;

   localparam int LINES = 1 << `CACHE_INDEX_W;

   typedef enum logic [1:0] {
      st_idle,
      st_lookup,  // RAM outputs valid, compare tag
      st_fill,    // refill running
      st_replay   // re-read after the tag write
   } state_t;

   state_t        state;
   state_t        state_nxt;
   cache_addr_t   addr_q;   // accepted request
   logic [LINES-1:0] valid_q;
   tag_entry_t    stored;
   logic          hit;
   logic          accept;
   logic          fill_done;

   assign stored = '{valid: valid_q[addr_q.index], tag: tag_rdata};
   assign hit    = stored.valid && (stored.tag == addr_q.tag);

   // a hit frees the port in the same cycle, so hits go back to back
   assign req_ready = (state == st_idle) || (state == st_lookup && hit);
   assign accept    = req_valid && req_ready;
   assign rsp_valid = (state == st_lookup) && hit;
   assign rsp_rdata = data_rdata;

   assign ctl.replace_valid = (state == st_lookup) && !hit;
   assign ctl.replace_addr  = {addr_q.tag, addr_q.index};

   assign fill_done = (state == st_fill) && !ctl.replace;

   assign tag_addr  = accept ? req_addr.index : addr_q.index;
   assign tag_we    = fill_done;  // tag goes in once the burst is clean
   assign tag_wdata = addr_q.tag;

   // refill beats own the data RAM while the engine is busy
   always_comb begin
      if (state == st_fill) begin
         data_addr = {addr_q.index, ctl.read_addr};
      end else if (accept) begin
         data_addr = {req_addr.index, req_addr.word_sel};
      end else begin
         data_addr = {addr_q.index, addr_q.word_sel};
      end
   end

   always_comb begin
      state_nxt = state;
      case (state)
         st_idle: begin
            if (accept) begin
               state_nxt = st_lookup;
            end
         end
         st_lookup: begin
            if (!hit) begin
               state_nxt = st_fill;
            end else if (!accept) begin
               state_nxt = st_idle;
            end
         end
         st_fill: begin
            if (fill_done) begin
               state_nxt = st_replay;
            end
         end
         default: state_nxt = st_lookup;  // replayed read now hits
      endcase
   end

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         state   <= st_idle;
         valid_q <= '0;  // all lines invalid
      end else begin
         state <= state_nxt;
         if (fill_done) begin
            valid_q[addr_q.index] <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         addr_q <= req_addr;
      end
   end

endmodule

// ==== verilog/cache_pkg.sv ====
`include "cache_consts.svh"

package cache_pkg;

   // one cache word, same width as the bus word
   typedef logic [`CACHE_WORD_W-1:0] word_t;

   typedef logic [`CACHE_TAG_W-1:0] tag_t;

   // tag and index together, the refill request address
   typedef logic [`CACHE_TAG_W+`CACHE_INDEX_W-1:0] line_addr_t;

   typedef logic [`CACHE_LINE_OFF_W-1:0] word_sel_t;

   // stored tag with its valid bit
   typedef struct packed {
      logic valid;
      tag_t tag;
   } tag_entry_t;

   // byte address as seen on the front port
   typedef struct packed {
      tag_t                          tag;
      logic [`CACHE_INDEX_W-1:0]     index;
      word_sel_t                     word_sel;
      logic [`CACHE_BYTE_OFF_W-1:0]  byte_off;  // ignored, word access only
   } cache_addr_t;

endpackage

// ==== verilog/cache_ram.sv ====
`timescale 1ns/1ns

// single-port synchronous RAM, one cycle read latency
module cache_ram #(
   parameter int  DEPTH_W   = 4,
   parameter type payload_t = logic [7:0]
) (
   input  logic               clk,
   input  logic [DEPTH_W-1:0] addr,
   input  logic               we,
   input  payload_t           wdata,
   output payload_t           rdata
);

   localparam int DEPTH = 1 << DEPTH_W;

   payload_t mem [DEPTH];

   // read returns the old content on a write cycle
   always_ff @(posedge clk) begin
      if (we) begin
         mem[addr] <= wdata;
      end
      rdata <= mem[addr];
   end

endmodule

// ==== verilog/cache_top.sv ====
`timescale 1ns/1ns
`include "cache_consts.svh"

module cache_top (
   input  logic                       clk,
   input  logic                       reset,

   // front port
   input  logic                       req_valid,
   input  cache_pkg::cache_addr_t     req_addr,
   output logic                       req_ready,
   output logic                       rsp_valid,
   output cache_pkg::word_t           rsp_rdata,

   // AXI4 read address channel
   output logic                       arvalid,
   output logic [`CACHE_ADDR_W-1:0]   araddr,
   output logic [7:0]                 arlen,
   output logic [2:0]                 arsize,
   output logic [1:0]                 arburst,
   output logic                       arlock,
   output logic [3:0]                 arcache,
   output logic [2:0]                 arprot,
   output logic [3:0]                 arqos,
   output logic [`CACHE_AXI_ID_W-1:0] arid,
   input  logic                       arready,

   // AXI4 read data channel
   input  logic                       rvalid,
   input  cache_pkg::word_t           rdata,
   input  logic [1:0]                 rresp,
   input  logic                       rlast,
   output logic                       rready
);
   import cache_pkg::*;

   logic [`CACHE_INDEX_W-1:0]                   tag_addr;
   logic                                        tag_we;
   tag_t                                        tag_wdata;
   tag_t                                        tag_rdata;
   logic [`CACHE_INDEX_W+`CACHE_LINE_OFF_W-1:0] data_addr;
   word_t                                       data_rdata;

   line_fill_if fill_bus ();

   cache_ram #(
      .DEPTH_W   (`CACHE_INDEX_W),
      .payload_t (tag_t)
   ) i_tag_ram (
      .clk   (clk),
      .addr  (tag_addr),
      .we    (tag_we),
      .wdata (tag_wdata),
      .rdata (tag_rdata)
   );

   // written only by refill beats
   cache_ram #(
      .DEPTH_W   (`CACHE_INDEX_W + `CACHE_LINE_OFF_W),
      .payload_t (word_t)
   ) i_data_ram (
      .clk   (clk),
      .addr  (data_addr),
      .we    (fill_bus.read_valid),
      .wdata (fill_bus.read_rdata),
      .rdata (data_rdata)
   );

   cache_lookup_ctrl i_ctrl (
      .clk        (clk),
      .reset      (reset),
      .req_valid  (req_valid),
      .req_addr   (req_addr),
      .req_ready  (req_ready),
      .rsp_valid  (rsp_valid),
      .rsp_rdata  (rsp_rdata),
      .tag_addr   (tag_addr),
      .tag_we     (tag_we),
      .tag_wdata  (tag_wdata),
      .tag_rdata  (tag_rdata),
      .data_addr  (data_addr),
      .data_rdata (data_rdata),
      .ctl        (fill_bus.ctrl)
   );

   cache_line_fill i_fill (
      .clk     (clk),
      .reset   (reset),
      .fill    (fill_bus.fill),
      .arvalid (arvalid),
      .araddr  (araddr),
      .arlen   (arlen),
      .arsize  (arsize),
      .arburst (arburst),
      .arlock  (arlock),
      .arcache (arcache),
      .arprot  (arprot),
      .arqos   (arqos),
      .arid    (arid),
      .arready (arready),
      .rvalid  (rvalid),
      .rdata   (rdata),
      .rresp   (rresp),
      .rlast   (rlast),
      .rready  (rready)
   );

endmodule

// ==== verilog/line_fill_if.sv ====
`timescale 1ns/1ns

interface line_fill_if;
   import cache_pkg::*;

   logic       replace_valid;  // one-cycle refill request
   line_addr_t replace_addr;
   logic       replace;        // refill engine busy
   logic       read_valid;     // one beat to store
   word_sel_t  read_addr;
   word_t      read_rdata;

   modport ctrl (
      output replace_valid,
      output replace_addr,
      input  replace,
      input  read_valid,
      input  read_addr,
      input  read_rdata
   );

   modport fill (
      input  replace_valid,
      input  replace_addr,
      output replace,
      output read_valid,
      output read_addr,
      output read_rdata
   );

endinterface
